/* Makefile */
# Verilator build and run of the word aligner testbench
# variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_word_aligner_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message appears in the simulation output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/word_aligner_params.svh */
// word aligner build constants
// lane geometry, lane count, training word and lock threshold
// serial bit order select and the preamble words
`ifndef WORD_ALIGNER_PARAMS_SVH
`define WORD_ALIGNER_PARAMS_SVH

// ------------------------------
// lane geometry
// ------------------------------
`define WA_DESER_WIDTH		6						// bits per lane group per clk
`define WA_WORD_WIDTH		(2*`WA_DESER_WIDTH)		// two groups per pixel word
`define WA_CHANNEL_NUM		4						// lvds data lanes

// ------------------------------
// training and lock
// ------------------------------
`define WA_TRAIN_WORD		12'h3A6					// no self-match at any other shift
`define WA_LOCK_HITS		3						// same-offset hits before commit

// 0 = lsb arrives first, 1 = msb arrives first
`define WA_SER_MSB_FIRST	0

// preamble words ahead of the sync code
`define WA_SYNC_ONES		{`WA_WORD_WIDTH{1'b1}}
`define WA_SYNC_ZERO		{`WA_WORD_WIDTH{1'b0}}

`endif

/* common/word_aligner_pkg.sv */
// shared types of the word aligner
// vector typedefs for groups, words, offsets and hit flags
// lock and preamble state encodings
`include "word_aligner_params.svh"

package word_aligner_pkg;

	// ------------------------------
	// data vectors
	// ------------------------------
	typedef logic [`WA_DESER_WIDTH-1:0]	deser_t;	// one lane group
	typedef logic [`WA_WORD_WIDTH-1:0]	word_t;		// one pixel word

	// bit offset of the word boundary inside a group, 0..5
	typedef logic [2:0]					offset_t;

	// one match flag per candidate offset
	typedef logic [`WA_DESER_WIDTH-1:0]	hit_t;

	// ------------------------------
	// state machines
	// ------------------------------
	typedef enum logic {
		LOCK_HUNT,		// no offset committed yet
		LOCK_LOCKED		// offset committed, word_en running
	} lock_state_e;

	// progress through ones, zero, zero
	typedef enum logic [1:0] {
		PRE_IDLE,
		PRE_ONES,
		PRE_ZERO1,
		PRE_ZERO2		// next word is the sync code
	} pre_state_e;

endpackage

/* filelist.f */
+incdir+common
common/word_aligner_pkg.sv
word_aligner/word_pattern_detect.sv
word_aligner/word_lock_ctrl.sv
word_aligner/word_extract.sv
word_aligner/word_aligner.sv
rtl/word_aligner_top.sv
verification/tb_word_aligner_top.sv

/* rtl/word_aligner_top.sv */
// multi-lane word aligner top
// one aligner per lane over the packed input and output buses
// lane 0 enable and sync flag exported for the whole group
`timescale 1ns/1ps
`include "word_aligner_params.svh"

module word_aligner_top (
	input	logic										clk,
	input	logic										rst_n,
	input	logic [`WA_CHANNEL_NUM*`WA_DESER_WIDTH-1:0]	iv_data,	// lane 0 in the low bits
	output	logic										o_clk_en,	// lane 0 word strobe
	output	logic										o_sync,		// lane 0 sync flag
	output	logic [`WA_CHANNEL_NUM*`WA_WORD_WIDTH-1:0]	ov_data		// lane words, packed
);

	logic [`WA_CHANNEL_NUM-1:0]	lane_clk_en;
	logic [`WA_CHANNEL_NUM-1:0]	lane_sync;

	// ------------------------------
	// lane instances
	// ------------------------------
	genvar i;
	generate
		for (i = 0; i < `WA_CHANNEL_NUM; i++) begin : gen_lane
			word_aligner u_lane (
				.clk		(clk),
				.rst_n		(rst_n),
				.iv_data	(iv_data[i*`WA_DESER_WIDTH +: `WA_DESER_WIDTH]),
				.o_clk_en	(lane_clk_en[i]),
				.o_sync		(lane_sync[i]),
				.ov_data	(ov_data[i*`WA_WORD_WIDTH +: `WA_WORD_WIDTH])
			);
		end
	endgenerate

	// lanes share word phase, lane 0 speaks for all
	assign o_clk_en = lane_clk_en[0];
	assign o_sync   = lane_sync[0];

endmodule

/* verification/tb_word_aligner_top.sv */
// testbench for the multi-lane word aligner
// serial lane model with random bit offsets over a shared word queue
// reference word sequence, compare process on o_clk_en and a watchdog
`timescale 1ns/1ps
`include "word_aligner_params.svh"

module tb_word_aligner_top
	import word_aligner_pkg::*;
();

	localparam int NL       = `WA_CHANNEL_NUM;
	localparam int GW       = `WA_DESER_WIDTH;
	localparam int WW       = `WA_WORD_WIDTH;
	localparam int MAXB     = 1024;		// bits per lane stream
	localparam int MAXW     = 128;		// expected words per lane
	localparam int N_TRAIN  = 8;		// training words per block
	localparam int IDLE_CYC = 10;
	localparam int MARGIN   = 60;
	localparam int K_PAY    = 0;
	localparam int K_TRAIN  = 1;
	localparam int K_PAD    = 2;		// offset shift slot
	localparam word_t TRAIN = `WA_TRAIN_WORD;
	localparam word_t ONES  = `WA_SYNC_ONES;
	localparam word_t ZERO  = `WA_SYNC_ZERO;

	logic				clk;
	logic				rst_n;
	logic [NL*GW-1:0]	iv_data;
	logic				o_clk_en;
	logic				o_sync;
	logic [NL*WW-1:0]	ov_data;

	// ------------------------------
	// stimulus model
	// ------------------------------
	logic [NL*WW-1:0]	slot_q[$];			// one word per lane per slot
	int					kind_q[$];
	bit					bit_mem [NL][MAXB];	// serial stream per lane
	int					bit_len [NL];
	int					off_init [NL];
	int					off_new0;			// lane 0 offset after retrain

	// checker state
	word_t				exp_mem [NL][MAXW];
	bit					exp_resync [NL][MAXW];	// first word after a training block
	int					exp_len [NL];
	int					rd_idx [NL];
	int					lane_mode [NL];		// 0 compare, 1 wait train, 2 skip train
	word_t				last_w0;			// newest expected word of lane 0
	word_t				last_w1;
	word_t				last_w2;
	bit					exp_sync;
	bit					seen_en;
	int					en_gap;
	bit					pre_train;
	bit					stim_built;
	bit					all_done;
	bit					done_now;
	int					chk_cnt;
	int					err_cnt;

	word_aligner_top DUT (
		.clk		(clk),
		.rst_n		(rst_n),
		.iv_data	(iv_data),
		.o_clk_en	(o_clk_en),
		.o_sync		(o_sync),
		.ov_data	(ov_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;		// 4 ns period
	end

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error %s expected %0h got %0h", name, exp, got);
		end
	endtask

	// random pixel word, never a preamble or training word
	function automatic word_t rand_word();
		word_t w;
		do begin
			w = word_t'($urandom);
		end while (w == ZERO || w == ONES || w == TRAIN);
		return w;
	endfunction

	task automatic add_slot(input int kind, input logic [NL*WW-1:0] w);
		slot_q.push_back(w);
		kind_q.push_back(kind);
	endtask

	task automatic add_same(input word_t w);
		add_slot(K_PAY, {NL{w}});
	endtask

	task automatic add_random(input int n);
		logic [NL*WW-1:0] v;
		for (int s = 0; s < n; s++) begin
			for (int i = 0; i < NL; i++)
				v[i*WW +: WW] = rand_word();	// own data per lane
			add_slot(K_PAY, v);
		end
	endtask

	task automatic add_training();
		for (int s = 0; s < N_TRAIN; s++)
			add_slot(K_TRAIN, {NL{TRAIN}});
	endtask

	// ------------------------------
	// word sequence
	// ------------------------------
	task automatic build_stimulus();
		add_training();
		add_random(10);
		add_same(ONES);				// good preamble, sync on the next word
		add_same(ZERO);
		add_same(ZERO);
		add_random(4);
		add_same(ONES);				// broken preamble
		add_same(ZERO);
		add_random(4);
		add_same(ONES);				// repeated ones then zero, zero
		add_same(ONES);
		add_same(ZERO);
		add_same(ZERO);
		add_random(4);
		add_slot(K_PAD, '0);		// lane 0 bit offset moves here
		add_training();
		add_random(8);
		add_same(ONES);
		add_same(ZERO);
		add_same(ZERO);
		add_random(4);
	endtask

	// cut the words into per-lane bit streams
	task automatic serialize_lanes();
		int p;
		word_t w;
		for (int i = 0; i < NL; i++) begin
			p = off_init[i];		// leading zeros set the offset
			foreach (slot_q[s]) begin
				if (kind_q[s] == K_PAD) begin
					// two word slots, lane 0 plus its offset change
					p += (i == 0) ? 2*WW + off_new0 - off_init[0] : 2*WW;
				end else begin
					w = slot_q[s][i*WW +: WW];
					for (int b = 0; b < WW; b++) begin
						bit_mem[i][p] = (`WA_SER_MSB_FIRST != 0) ? w[WW-1-b] : w[b];
						p++;
					end
				end
			end
			bit_len[i] = p;
		end
	endtask

	// reference: payload words after each training block, in order
	function automatic int expected_words(input int lane);
		int n;
		bit after_train;
		n = 0;
		after_train = 1'b0;
		foreach (slot_q[s]) begin
			if (kind_q[s] == K_TRAIN) begin
				after_train = 1'b1;
			end else if (kind_q[s] == K_PAY) begin
				exp_mem[lane][n]    = slot_q[s][lane*WW +: WW];
				exp_resync[lane][n] = after_train;
				after_train         = 1'b0;
				n++;
			end
		end
		return n;
	endfunction

	task automatic drive_group(input int g);
		logic [NL*GW-1:0] v;
		int p;
		v = '0;
		for (int i = 0; i < NL; i++) begin
			for (int j = 0; j < GW; j++) begin
				p = g*GW + j;
				if (p < MAXB) begin
					if (`WA_SER_MSB_FIRST != 0)
						v[i*GW + GW-1-j] = bit_mem[i][p];	// first bit on top
					else
						v[i*GW + j] = bit_mem[i][p];
				end
			end
		end
		@(posedge clk);
		#1 iv_data = v;
	endtask

	task automatic drive_zero();
		@(posedge clk);
		#1 iv_data = '0;
	endtask

	// one word of one lane, resync after training on the first non-training word
	task automatic compare_lane(input int i, input word_t got);
		word_t exp;
		if (rd_idx[i] >= exp_len[i])
			return;
		if (lane_mode[i] == 0 && exp_resync[i][rd_idx[i]]) begin
			lane_mode[i] = 1;
			if (i == 0) begin
				last_w0 = '0;
				last_w1 = '0;
				last_w2 = '0;
			end
		end
		if (lane_mode[i] == 1) begin
			if (got == TRAIN)
				lane_mode[i] = 2;
			return;					// lock in progress
		end
		if (lane_mode[i] == 2) begin
			if (got == TRAIN)
				return;
			lane_mode[i] = 0;
		end
		exp = exp_mem[i][rd_idx[i]];
		check_value($sformatf("ov_data[lane %0d]", i), 64'(got), 64'(exp));
		if (i == 0) begin
			exp_sync = (last_w2 == ONES) && (last_w1 == ZERO) && (last_w0 == ZERO);
			last_w2  = last_w1;
			last_w1  = last_w0;
			last_w0  = exp;
		end
		rd_idx[i]++;
	endtask

	// ------------------------------
	// compare process, outputs stable at negedge
	// ------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			exp_sync = 1'b0;
			if (pre_train) begin
				check_value("o_clk_en", 64'(o_clk_en), 64'(0));
				check_value("ov_data", 64'(ov_data), 64'(0));
			end
			if (o_clk_en) begin
				if (seen_en)
					check_value("o_clk_en gap", 64'(en_gap), 64'(1));	// every second cycle
				seen_en = 1'b1;
				en_gap  = 0;
				for (int i = 0; i < NL; i++)
					compare_lane(i, ov_data[i*WW +: WW]);
			end else if (seen_en) begin
				en_gap++;
				if (en_gap == 2)
					check_value("o_clk_en gap", 64'(en_gap), 64'(1));	// strobe missing
			end
			check_value("o_sync", 64'(o_sync), 64'(exp_sync));
			if (stim_built) begin
				done_now = 1'b1;
				for (int i = 0; i < NL; i++)
					if (rd_idx[i] < exp_len[i])
						done_now = 1'b0;
				all_done = done_now;
			end
		end
	end

	// watchdog, two cycles per word plus reset, idle and margin
	initial begin
		wait (stim_built);
		repeat (IDLE_CYC + 3 + 2*slot_q.size() + MARGIN) @(posedge clk);
		if (!seen_en)
			$display("timeout: no lock");
		else
			$display("timeout: stream did not finish");
		$display("checks: %0d errors: %0d", chk_cnt, err_cnt);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int n_groups;
		iv_data   = '0;
		rst_n     = 1'b0;
		pre_train = 1'b1;
		last_w0   = '0;
		last_w1   = '0;
		last_w2   = '0;
		void'($urandom(27));
		for (int i = 0; i < NL; i++)
			off_init[i] = $urandom_range(0, GW-1);
		off_new0 = (off_init[0] + 1 + int'($urandom_range(0, GW-2))) % GW;	// always a new offset
		build_stimulus();
		serialize_lanes();
		n_groups = 0;
		for (int i = 0; i < NL; i++) begin
			exp_len[i] = expected_words(i);
			if ((bit_len[i] + GW - 1) / GW > n_groups)
				n_groups = (bit_len[i] + GW - 1) / GW;
		end
		stim_built = 1'b1;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (IDLE_CYC) drive_zero();		// no training yet, outputs must stay quiet
		pre_train = 1'b0;
		for (int g = 0; g < n_groups; g++)
			drive_group(g);
		while (!all_done)
			drive_zero();					// flush the pipeline
		$display("checks: %0d errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* word_aligner/word_aligner.sv */
// single-lane word aligner
// pattern detect, lock control and word extract in series
// lock level stays internal to the lane
`timescale 1ns/1ps
`include "word_aligner_params.svh"

module word_aligner
	import word_aligner_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,
	input	deser_t		iv_data,	// deserialized group
	output	logic		o_clk_en,	// word-rate enable
	output	logic		o_sync,		// sync code flag
	output	word_t		ov_data		// aligned pixel word
);

	logic [3*`WA_DESER_WIDTH-1:0]	window;		// last three groups
	hit_t							hits;
	offset_t						offset;
	logic							word_en;

	// ------------------------------
	// decode
	// ------------------------------
	word_pattern_detect u_detect (
		.clk		(clk),
		.rst_n		(rst_n),
		.iv_data	(iv_data),
		.window		(window),
		.hits		(hits)
	);

	// execute, lock level not exported
	word_lock_ctrl u_lock (
		.clk		(clk),
		.rst_n		(rst_n),
		.hits		(hits),
		.offset		(offset),
		.word_en	(word_en),
		.locked		()
	);

	// result
	word_extract u_extract (
		.clk		(clk),
		.rst_n		(rst_n),
		.window		(window),
		.offset		(offset),
		.word_en	(word_en),
		.data		(ov_data),
		.clk_en		(o_clk_en),
		.sync		(o_sync)
	);

endmodule

/* word_aligner/word_extract.sv */
// word rebuild for one lane
// slice at the committed offset, back to serial order
// output data register and word-rate clk_en
// preamble tracker for ones, zero, zero and the sync flag
`timescale 1ns/1ps
`include "word_aligner_params.svh"

module word_extract
	import word_aligner_pkg::*;
(
	input	logic							clk,
	input	logic							rst_n,
	input	logic [3*`WA_DESER_WIDTH-1:0]	window,		// lsb-first group history
	input	offset_t						offset,		// committed boundary
	input	logic							word_en,	// window holds a full word
	output	word_t							data,		// rebuilt pixel word
	output	logic							clk_en,		// data valid strobe
	output	logic							sync		// data is the sync code
);

	word_t		slice_raw;	// word in window bit order
	word_t		slice;		// word in serial bit order
	pre_state_e	pre_state;
	pre_state_e	pre_next;

	assign slice_raw = window[offset +: `WA_WORD_WIDTH];

	// undo the normalization done in the detector
	always_comb begin
		if (`WA_SER_MSB_FIRST != 0)
			slice = {<<{slice_raw}};
		else
			slice = slice_raw;
	end

	// ------------------------------
	// preamble tracker
	// ------------------------------
	always_comb begin
		pre_next = PRE_IDLE;					// any other word breaks the run
		if (slice == `WA_SYNC_ONES) begin
			pre_next = PRE_ONES;				// repeated ones keep us here
		end else if (slice == `WA_SYNC_ZERO) begin
			case (pre_state)
				PRE_ONES:  pre_next = PRE_ZERO1;
				PRE_ZERO1: pre_next = PRE_ZERO2;
				default:   pre_next = PRE_IDLE;	// zero without ones first
			endcase
		end
	end

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data      <= '0;
			clk_en    <= 1'b0;
			sync      <= 1'b0;
			pre_state <= PRE_IDLE;
		end else begin
			clk_en <= word_en;								// same edge as data
			sync   <= word_en && (pre_state == PRE_ZERO2);	// word after zero, zero
			if (word_en) begin
				data      <= slice;
				pre_state <= pre_next;
			end
		end
	end

endmodule

/* word_aligner/word_lock_ctrl.sv */
// offset lock control for one lane
// candidate offset with a consecutive-hit counter and expected-hit phase
// commit and recommit after WA_LOCK_HITS hits two cycles apart
// half-rate word_en aligned to the committed hit parity
`timescale 1ns/1ps
`include "word_aligner_params.svh"

module word_lock_ctrl
	import word_aligner_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,
	input	hit_t		hits,		// registered per-offset matches
	output	offset_t	offset,		// committed word offset
	output	logic		word_en,	// high on every second cycle once locked
	output	logic		locked		// level, stays up through recommits
);

	localparam int unsigned CNT_W = $clog2(`WA_LOCK_HITS + 1);

	lock_state_e		state;
	offset_t			cand;		// offset under test
	logic [CNT_W-1:0]	hit_cnt;	// zero means no candidate
	logic				exp_ph;		// a candidate hit is due this cycle
	offset_t			first_hit;	// lowest offset with a match
	logic				any_hit;
	logic				cand_hit;	// candidate matched on its expected cycle
	logic				commit;

	// lowest set flag wins when several offsets match
	always_comb begin
		first_hit = '0;
		for (int i = `WA_DESER_WIDTH - 1; i >= 0; i--) begin
			if (hits[i])
				first_hit = offset_t'(i);
		end
	end

	assign any_hit  = |hits;
	assign cand_hit = (hit_cnt != '0) && exp_ph && hits[cand];
	assign commit   = cand_hit && (hit_cnt >= CNT_W'(`WA_LOCK_HITS - 1));
	assign locked   = (state == LOCK_LOCKED);

	// ------------------------------
	// candidate tracking
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cand    <= '0;
			hit_cnt <= '0;
			exp_ph  <= 1'b0;
		end else if (cand_hit) begin
			if (hit_cnt != CNT_W'(`WA_LOCK_HITS))
				hit_cnt <= hit_cnt + 1'b1;		// saturate at the threshold
			exp_ph <= 1'b0;					// next hit due in two cycles
		end else if (any_hit) begin
			cand    <= first_hit;			// other offset or wrong parity, restart
			hit_cnt <= CNT_W'(1);
			exp_ph  <= 1'b0;
		end else begin
			if (exp_ph)
				hit_cnt <= '0;				// expected hit missing
			exp_ph <= ~exp_ph;
		end
	end

	// ------------------------------
	// commit and word phase
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= LOCK_HUNT;
			offset  <= '0;
			word_en <= 1'b0;
		end else if (commit) begin
			state   <= LOCK_LOCKED;
			offset  <= cand;
			word_en <= 1'b1;				// next window holds a whole word at cand
		end else if (locked) begin
			word_en <= ~word_en;			// free-running half-rate toggle
		end else begin
			word_en <= 1'b0;
		end
	end

endmodule

/* word_aligner/word_pattern_detect.sv */
// training word search for one lane
// three-group window with serial bit order normalized to lsb first
// registered match flag for each of the six bit offsets
`timescale 1ns/1ps
`include "word_aligner_params.svh"

module word_pattern_detect
	import word_aligner_pkg::*;
(
	input	logic							clk,
	input	logic							rst_n,
	input	deser_t							iv_data,	// group from the deserializer
	output	logic [3*`WA_DESER_WIDTH-1:0]	window,		// oldest group in the low bits
	output	hit_t							hits		// one flag per offset
);

	// training word in window bit order
	localparam word_t TRAIN_LSB = `WA_TRAIN_WORD;
	localparam word_t TRAIN_REV = {<<{TRAIN_LSB}};
	localparam word_t TRAIN_NORM = (`WA_SER_MSB_FIRST != 0) ? TRAIN_REV : TRAIN_LSB;

	deser_t	grp_norm;	// incoming group, first bit at index 0
	hit_t	hit_now;	// compare result on the current window

	// msb-first lanes put the earliest bit on top, flip it down
	always_comb begin
		if (`WA_SER_MSB_FIRST != 0)
			grp_norm = {<<{iv_data}};
		else
			grp_norm = iv_data;
	end

	// ------------------------------
	// per-offset compare
	// ------------------------------
	always_comb begin
		for (int o = 0; o < `WA_DESER_WIDTH; o++) begin
			hit_now[o] = (window[o +: `WA_WORD_WIDTH] == TRAIN_NORM);	// 12 bits from offset o
		end
	end

	// ------------------------------
	// window shift and hit register
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			window <= '0;
			hits   <= '0;
		end else begin
			// newest group enters at the top, oldest drops out the bottom
			window <= {grp_norm, window[3*`WA_DESER_WIDTH-1:`WA_DESER_WIDTH]};
			hits   <= hit_now;		// one cycle behind window
		end
	end

endmodule
